// ==== common/mpmc_mem_pkg.sv ====
`default_nettype none

package mpmc_mem_pkg;

	// ==============================
	// DDR user interface geometry
	// ==============================

	// Byte address width on the memory side
	localparam int addr_w = 29;

	// One strip is a full user interface data beat
	localparam int strip_w = 128;
	localparam int strip_bytes = strip_w / 8;

	// Command codes on mem_cmd
	localparam logic [2:0] cmd_read = 3'b001;
	localparam logic [2:0] cmd_write = 3'b000;

	// ==============================
	// Transaction FSM
	// ==============================

	typedef enum logic [2:0] {
		idle       = 3'd0,
		preset     = 3'd1,
		send_data  = 3'd2,
		set_cmd_rd = 3'd3,
		set_cmd_wr = 3'd4,
		wait_rd    = 3'd5,
		wait_nack  = 3'd6
	} ctrl_state_t;

	// Everything that goes out on the memory pins, apart from the enables
	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [2:0] cmd;
		logic [strip_w-1:0] wdata;
		// Set bits mask off bytes, as on the DDR interface
		logic [strip_bytes-1:0] wmask;
	} mem_req_t;

endpackage

`default_nettype wire

// ==== common/mpmc_chan_pkg.sv ====
`default_nettype none

package mpmc_chan_pkg;

	// ==============================
	// Channels
	// ==============================

	localparam int num_ch = 2;

	typedef logic ch_id_t;

	localparam ch_id_t ch_cpu = 1'b0;
	localparam ch_id_t ch_dma = 1'b1;

	// Longest read burst of any channel, in strips
	localparam int max_strips = 2;

	typedef logic [$clog2(max_strips)-1:0] strip_idx_t;
	typedef logic [mpmc_mem_pkg::strip_w-1:0] strip_t;
	typedef logic [mpmc_mem_pkg::strip_bytes-1:0] strip_mask_t;

	// Cycles to wait for the master to release before giving up
	localparam int nack_limit = 5;
	typedef logic [$clog2(nack_limit+1)-1:0] nack_cnt_t;

	// Grants between two reversed-priority grants
	localparam int elevate_period = 64;
	typedef logic [$clog2(elevate_period)-1:0] elevate_cnt_t;

	// ==============================
	// Port to arbiter and control
	// ==============================

	typedef struct packed {
		logic wr_req;
		logic rd_miss;
	} port_need_t;

	typedef struct packed {
		logic [31:0] adr;
		logic we;
		strip_t data;
		strip_mask_t mask;
		// Index of the last strip of the burst
		strip_idx_t num_strips;
	} port_cmd_t;

	typedef struct packed {
		logic valid;
		ch_id_t ch;
		logic we;
		strip_idx_t num_strips;
	} grant_t;

	typedef struct packed {
		logic valid;
		ch_id_t ch;
		strip_idx_t idx;
	} fill_t;

endpackage

`default_nettype wire

// ==== hw/channel_port/channel_port.sv ====
`default_nettype none

module channel_port
	import mpmc_chan_pkg::*;
#(
	parameter type data_t = logic [63:0]
) (
	input wire logic mem_ui_clk,
	input wire logic mem_ui_rst,
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input wire logic [$bits(data_t)/8-1:0] sel,
	input wire logic [31:0] adr,
	input wire data_t dati,
	input wire fill_t fill,
	input wire logic wr_done,
	input wire ch_id_t my_id,
	input wire strip_t rd_strip,
	input wire logic [31:0] inval_adr,
	input wire logic inval_en,
	output data_t dato,
	output logic ack,
	output port_need_t need,
	output port_cmd_t cmd,
	output logic [31:0] wr_adr,
	output logic wr_en
);

	// ==============================
	// Line geometry
	// ==============================

	localparam int data_w = $bits(data_t);
	localparam int strip_bits = $bits(strip_t);
	localparam int words_per_strip = strip_bits / data_w;
	// 64-bit payload gets a two-strip line, 32-bit a single strip
	localparam int line_strips = data_w / 32;
	localparam int line_bytes = line_strips * strip_bits / 8;
	localparam int line_lsb = $clog2(line_bytes);
	localparam int word_bytes = data_w / 8;
	localparam int word_lsb = $clog2(word_bytes);
	localparam strip_idx_t last_idx = strip_idx_t'(line_strips - 1);

	logic [line_strips*strip_bits-1:0] line_q;
	logic [31-line_lsb:0] tag_q;
	logic valid_q;
	logic ack_q;
	logic cs;
	logic hit;
	logic fill_mine;
	logic fill_last;
	logic kill;
	logic [line_lsb-word_lsb-1:0] word_off;
	logic [3:0] strip_off;
	logic [31:0] strip_adr;
	logic [31:0] line_adr;
	strip_mask_t byte_en;

	assign cs = cyc && stb;
	assign hit = cs && !we && valid_q && (adr[31:line_lsb] == tag_q);

	assign fill_mine = fill.valid && (fill.ch == my_id);
	assign fill_last = fill_mine && (fill.idx == last_idx);

	// Any write into this line, from either channel, drops the line
	assign kill = (inval_en && inval_adr[31:line_lsb] == tag_q) ||
		(wr_done && strip_adr[31:line_lsb] == tag_q);

	// ==============================
	// Cache storage and tag
	// ==============================

	always_ff @(posedge mem_ui_clk) begin
		if (fill_mine) begin
			line_q[int'(fill.idx) * strip_bits +: strip_bits] <= rd_strip;
			if (fill.idx == last_idx)
				tag_q <= adr[31:line_lsb];
		end
	end

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			valid_q <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			if (kill)
				valid_q <= 1'b0;
			if (fill_last)
				valid_q <= 1'b1;
			// Ack holds until the master lets go
			if (!cs)
				ack_q <= 1'b0;
			else if (hit || wr_done)
				ack_q <= 1'b1;
		end
	end

	assign ack = ack_q && cs;

	// Read word out of the cached line
	assign word_off = adr[line_lsb-1:word_lsb];
	assign dato = line_q[int'(word_off) * data_w +: data_w];

	// ==============================
	// Write formatting and requests
	// ==============================

	assign strip_adr = {adr[31:4], 4'h0};
	assign line_adr = adr & ~32'(line_bytes - 1);
	assign strip_off = adr[3:0] & ~4'(word_bytes - 1);
	assign byte_en = strip_mask_t'(sel) << strip_off;

	assign cmd.adr = we ? strip_adr : line_adr;
	assign cmd.we = we;
	assign cmd.data = {words_per_strip{dati}};
	assign cmd.mask = ~byte_en;
	assign cmd.num_strips = we ? '0 : last_idx;

	// No need once acked, so a finished request is not granted again
	assign need.wr_req = cs && we && !ack_q;
	assign need.rd_miss = cs && !we && !hit && !ack_q;

	assign wr_adr = strip_adr;
	assign wr_en = wr_done;

	// Read data on ack comes from a valid line that holds the address
	assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		ack && !we |-> valid_q && (adr[31:line_lsb] == tag_q));

endmodule

`default_nettype wire

// ==== hw/channel_arb.sv ====
`default_nettype none

module channel_arb
	import mpmc_chan_pkg::*;
(
	input wire logic mem_ui_clk,
	input wire logic mem_ui_rst,
	input wire port_need_t needs [num_ch],
	input wire port_cmd_t cmds [num_ch],
	input wire logic idle,
	output grant_t grant
);

	grant_t pick;
	ch_id_t first;
	ch_id_t second;
	elevate_cnt_t elev_cnt;
	logic elevate;
	logic idle_d;
	logic any_need;

	// Every elevate_period grants the channel order flips for one grant
	assign elevate = (elev_cnt == elevate_cnt_t'(elevate_period - 1));
	assign first = elevate ? ch_dma : ch_cpu;
	assign second = ~first;

	// Writes before read misses, channel order inside each class
	always_comb begin
		pick = '0;
		if (needs[first].wr_req) begin
			pick.valid = 1'b1;
			pick.ch = first;
			pick.we = 1'b1;
		end else if (needs[second].wr_req) begin
			pick.valid = 1'b1;
			pick.ch = second;
			pick.we = 1'b1;
		end else if (needs[first].rd_miss) begin
			pick.valid = 1'b1;
			pick.ch = first;
		end else if (needs[second].rd_miss) begin
			pick.valid = 1'b1;
			pick.ch = second;
		end
		pick.num_strips = cmds[pick.ch].num_strips;
	end

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			grant <= '0;
			idle_d <= 1'b0;
			elev_cnt <= '0;
		end else begin
			idle_d <= idle;
			// Held for the whole transaction once the FSM leaves idle
			if (idle)
				grant <= pick;
			// One count per transaction started
			if (idle_d && !idle)
				elev_cnt <= elev_cnt + 1'b1;
		end
	end

	always_comb begin
		any_need = 1'b0;
		for (int i = 0; i < num_ch; i++) begin
			any_need = any_need | needs[i].wr_req | needs[i].rd_miss;
		end
	end

	// A grant that the FSM may start on still has its request behind it
	assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		idle_d && idle && grant.valid |-> any_need);

endmodule

`default_nettype wire

// ==== hw/mpmc_ctrl.sv ====
`default_nettype none

module mpmc_ctrl
	import mpmc_mem_pkg::*;
	import mpmc_chan_pkg::*;
(
	input wire logic mem_ui_clk,
	input wire logic mem_ui_rst,
	input wire grant_t grant,
	input wire logic mem_rdy,
	input wire logic mem_wdf_rdy,
	input wire logic mem_rd_data_valid,
	input wire logic [num_ch-1:0] acks,
	output ctrl_state_t state,
	output fill_t fill,
	output logic [num_ch-1:0] wr_done,
	output logic mem_en,
	output logic mem_wdf_wren,
	output logic mem_wdf_end
);

	ctrl_state_t state_nx;
	strip_idx_t issue_cnt;
	strip_idx_t ret_cnt;
	nack_cnt_t nack_cnt;
	logic idle_q;
	logic ack_d;
	logic rd_phase;
	logic last_issue;
	logic last_return;
	logic ack_fell;

	assign rd_phase = (state == set_cmd_rd) || (state == wait_rd);
	assign last_issue = mem_rdy && (issue_cnt == grant.num_strips);
	assign last_return = mem_rd_data_valid && (ret_cnt == grant.num_strips);
	assign ack_fell = ack_d && !acks[grant.ch];

	// ==============================
	// Transaction FSM
	// ==============================

	always_comb begin
		state_nx = state;
		case (state)
			// The grant is only fresh after a full cycle in idle
			idle: if (idle_q && grant.valid)
				state_nx = preset;
			preset: begin
				if (!grant.valid)
					state_nx = idle;
				else if (grant.we)
					state_nx = send_data;
				else
					state_nx = set_cmd_rd;
			end
			send_data: if (mem_wdf_rdy)
				state_nx = set_cmd_wr;
			set_cmd_wr: if (mem_rdy)
				state_nx = wait_nack;
			set_cmd_rd: begin
				if (last_return)
					state_nx = wait_nack;
				else if (last_issue)
					state_nx = wait_rd;
			end
			wait_rd: if (last_return)
				state_nx = wait_nack;
			wait_nack: if (ack_fell || nack_cnt == nack_cnt_t'(nack_limit))
				state_nx = idle;
			default: state_nx = idle;
		endcase
	end

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			state <= idle;
			idle_q <= 1'b0;
			ack_d <= 1'b0;
			issue_cnt <= '0;
			ret_cnt <= '0;
			nack_cnt <= '0;
		end else begin
			state <= state_nx;
			idle_q <= (state == idle);
			ack_d <= acks[grant.ch];
			// Strip counters, issued and returned
			if (state == idle) begin
				issue_cnt <= '0;
				ret_cnt <= '0;
			end else begin
				if (state == set_cmd_rd && mem_rdy && issue_cnt != grant.num_strips)
					issue_cnt <= issue_cnt + 1'b1;
				if (rd_phase && mem_rd_data_valid)
					ret_cnt <= ret_cnt + 1'b1;
			end
			if (state == wait_nack)
				nack_cnt <= nack_cnt + 1'b1;
			else
				nack_cnt <= '0;
		end
	end

	// ==============================
	// Outputs
	// ==============================

	// Strips come back in order, so the return count is the line slot
	assign fill.valid = rd_phase && mem_rd_data_valid;
	assign fill.ch = grant.ch;
	assign fill.idx = ret_cnt;

	always_comb begin
		for (int i = 0; i < num_ch; i++) begin
			wr_done[i] = (state == set_cmd_wr) && mem_rdy && (grant.ch == ch_id_t'(i));
		end
	end

	assign mem_en = (state == set_cmd_rd) || (state == set_cmd_wr);
	assign mem_wdf_wren = (state == send_data);
	assign mem_wdf_end = (state == send_data);

	// Read strips only come back while a read burst is open
	assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		mem_rd_data_valid |-> rd_phase);

endmodule

`default_nettype wire

// ==== hw/mem_cmd_path.sv ====
`default_nettype none

module mem_cmd_path
	import mpmc_mem_pkg::*;
	import mpmc_chan_pkg::*;
(
	input wire logic mem_ui_clk,
	input wire logic mem_rdy,
	input wire ctrl_state_t state,
	input wire grant_t grant,
	input wire port_cmd_t cmds [num_ch],
	output mem_req_t req
);

	logic [addr_w-1:0] addr_q;
	logic [strip_w-1:0] wdata_q;
	logic [strip_bytes-1:0] wmask_q;
	strip_idx_t step_q;
	port_cmd_t sel_cmd;

	// Command of the channel that holds the grant
	assign sel_cmd = cmds[grant.ch];

	// ==============================
	// Address, data and mask
	// ==============================

	always_ff @(posedge mem_ui_clk) begin
		if (state == preset) begin
			addr_q <= sel_cmd.adr[addr_w-1:0];
			wdata_q <= sel_cmd.data;
			wmask_q <= sel_cmd.mask;
			step_q <= '0;
		end else if (state == set_cmd_rd && mem_rdy && step_q != grant.num_strips) begin
			// Next strip of the read burst
			addr_q <= addr_q + addr_w'(strip_bytes);
			step_q <= step_q + 1'b1;
		end
	end

	// Command code follows the FSM
	always_comb begin
		req.addr = addr_q;
		req.cmd = (state == set_cmd_rd) ? cmd_read : cmd_write;
		req.wdata = wdata_q;
		req.wmask = wmask_q;
	end

endmodule

`default_nettype wire

// ==== hw/mpmc_top.sv ====
`default_nettype none

module mpmc_top
	import mpmc_mem_pkg::*;
	import mpmc_chan_pkg::*;
(
	input wire logic mem_ui_clk,
	input wire logic mem_ui_rst,

	// cpu channel, 64-bit
	input wire logic cpu_cyc,
	input wire logic cpu_stb,
	input wire logic cpu_we,
	input wire logic [7:0] cpu_sel,
	input wire logic [31:0] cpu_adr,
	input wire logic [63:0] cpu_dati,
	output logic [63:0] cpu_dato,
	output logic cpu_ack,

	// dma channel, 32-bit
	input wire logic dma_cyc,
	input wire logic dma_stb,
	input wire logic dma_we,
	input wire logic [3:0] dma_sel,
	input wire logic [31:0] dma_adr,
	input wire logic [31:0] dma_dati,
	output logic [31:0] dma_dato,
	output logic dma_ack,

	// DDR user interface
	output logic [addr_w-1:0] mem_addr,
	output logic [2:0] mem_cmd,
	output logic mem_en,
	output logic [strip_w-1:0] mem_wdf_data,
	output logic [strip_bytes-1:0] mem_wdf_mask,
	output logic mem_wdf_wren,
	output logic mem_wdf_end,
	input wire logic [strip_w-1:0] mem_rd_data,
	input wire logic mem_rd_data_valid,
	input wire logic mem_rdy,
	input wire logic mem_wdf_rdy
);

	port_need_t needs [num_ch];
	port_cmd_t cmds [num_ch];
	logic [31:0] wr_adr [num_ch];
	logic [num_ch-1:0] acks;
	logic [num_ch-1:0] wr_done;
	logic [num_ch-1:0] wr_en;
	grant_t grant;
	fill_t fill;
	ctrl_state_t state;
	mem_req_t req;
	logic ctrl_idle;

	assign ctrl_idle = (state == idle);
	assign cpu_ack = acks[ch_cpu];
	assign dma_ack = acks[ch_dma];

	// ==============================
	// Channel front ends
	// ==============================

	// Each port invalidates on the other port's writes
	channel_port #(.data_t(logic [63:0])) cpu_port_inst (
		.mem_ui_clk(mem_ui_clk),
		.mem_ui_rst(mem_ui_rst),
		.cyc(cpu_cyc),
		.stb(cpu_stb),
		.we(cpu_we),
		.sel(cpu_sel),
		.adr(cpu_adr),
		.dati(cpu_dati),
		.fill(fill),
		.wr_done(wr_done[ch_cpu]),
		.my_id(ch_cpu),
		.rd_strip(mem_rd_data),
		.inval_adr(wr_adr[ch_dma]),
		.inval_en(wr_en[ch_dma]),
		.dato(cpu_dato),
		.ack(acks[ch_cpu]),
		.need(needs[ch_cpu]),
		.cmd(cmds[ch_cpu]),
		.wr_adr(wr_adr[ch_cpu]),
		.wr_en(wr_en[ch_cpu])
	);

	channel_port #(.data_t(logic [31:0])) dma_port_inst (
		.mem_ui_clk(mem_ui_clk),
		.mem_ui_rst(mem_ui_rst),
		.cyc(dma_cyc),
		.stb(dma_stb),
		.we(dma_we),
		.sel(dma_sel),
		.adr(dma_adr),
		.dati(dma_dati),
		.fill(fill),
		.wr_done(wr_done[ch_dma]),
		.my_id(ch_dma),
		.rd_strip(mem_rd_data),
		.inval_adr(wr_adr[ch_cpu]),
		.inval_en(wr_en[ch_cpu]),
		.dato(dma_dato),
		.ack(acks[ch_dma]),
		.need(needs[ch_dma]),
		.cmd(cmds[ch_dma]),
		.wr_adr(wr_adr[ch_dma]),
		.wr_en(wr_en[ch_dma])
	);

	// ==============================
	// Arbitration and control
	// ==============================

	channel_arb channel_arb_inst (
		.mem_ui_clk(mem_ui_clk),
		.mem_ui_rst(mem_ui_rst),
		.needs(needs),
		.cmds(cmds),
		.idle(ctrl_idle),
		.grant(grant)
	);

	mpmc_ctrl mpmc_ctrl_inst (
		.mem_ui_clk(mem_ui_clk),
		.mem_ui_rst(mem_ui_rst),
		.grant(grant),
		.mem_rdy(mem_rdy),
		.mem_wdf_rdy(mem_wdf_rdy),
		.mem_rd_data_valid(mem_rd_data_valid),
		.acks(acks),
		.state(state),
		.fill(fill),
		.wr_done(wr_done),
		.mem_en(mem_en),
		.mem_wdf_wren(mem_wdf_wren),
		.mem_wdf_end(mem_wdf_end)
	);

	mem_cmd_path mem_cmd_path_inst (
		.mem_ui_clk(mem_ui_clk),
		.mem_rdy(mem_rdy),
		.state(state),
		.grant(grant),
		.cmds(cmds),
		.req(req)
	);

	assign mem_addr = req.addr;
	assign mem_cmd = req.cmd;
	assign mem_wdf_data = req.wdata;
	assign mem_wdf_mask = req.wmask;

endmodule

`default_nettype wire

// ==== bench/mig_model.sv ====
`default_nettype none

module mig_model
	import mpmc_mem_pkg::*;
(
	input wire logic mem_ui_clk,
	input wire logic mem_ui_rst,
	input wire logic [addr_w-1:0] mem_addr,
	input wire logic [2:0] mem_cmd,
	input wire logic mem_en,
	input wire logic [strip_w-1:0] mem_wdf_data,
	input wire logic [strip_bytes-1:0] mem_wdf_mask,
	input wire logic mem_wdf_wren,
	output logic [strip_w-1:0] mem_rd_data,
	output logic mem_rd_data_valid,
	output logic mem_rdy,
	output logic mem_wdf_rdy,
	input wire logic rdy_stall,
	input wire logic wdf_stall,
	output int rd_count,
	output logic [addr_w-1:0] last_wr_addr
);
	timeunit 1ns;
	timeprecision 1ps;

	// Cycles from an accepted read command to its strip
	localparam int read_latency = 3;

	typedef struct packed {
		logic [31:0] due;
		logic [strip_w-1:0] data;
	} ret_t;

	logic [7:0] mem [logic [addr_w-1:0]];
	logic [strip_w-1:0] wdata_q [$];
	logic [strip_bytes-1:0] wmask_q [$];
	ret_t ret_q [$];
	ret_t head;
	logic [31:0] cycle;

	assign mem_rdy = !rdy_stall;
	assign mem_wdf_rdy = !wdf_stall;

	// Unwritten bytes read back a pattern of their address
	function automatic logic [7:0] pattern_byte(input logic [addr_w-1:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {3'b000, a[28:24]} ^ 8'ha5;
	endfunction

	function automatic logic [strip_w-1:0] read_strip(input logic [addr_w-1:0] a);
		logic [strip_w-1:0] s;
		logic [addr_w-1:0] ba;
		for (int b = 0; b < strip_bytes; b++) begin
			ba = a + addr_w'(b);
			s[8*b +: 8] = mem.exists(ba) ? mem[ba] : pattern_byte(ba);
		end
		return s;
	endfunction

	// A set mask bit keeps the old byte
	task automatic write_strip(input logic [addr_w-1:0] a, input logic [strip_w-1:0] d,
			input logic [strip_bytes-1:0] m);
		for (int b = 0; b < strip_bytes; b++) begin
			if (!m[b])
				mem[a + addr_w'(b)] = d[8*b +: 8];
		end
	endtask

	always @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			mem_rd_data <= '0;
			mem_rd_data_valid <= 1'b0;
			rd_count <= 0;
			last_wr_addr <= '0;
			cycle <= '0;
			wdata_q.delete();
			wmask_q.delete();
			ret_q.delete();
		end else begin
			cycle <= cycle + 32'd1;
			// Strips go back in command order
			if (ret_q.size() > 0 && ret_q[0].due <= cycle) begin
				head = ret_q.pop_front();
				mem_rd_data <= head.data;
				mem_rd_data_valid <= 1'b1;
			end else begin
				mem_rd_data_valid <= 1'b0;
			end
			if (mem_wdf_wren && mem_wdf_rdy) begin
				wdata_q.push_back(mem_wdf_data);
				wmask_q.push_back(mem_wdf_mask);
			end
			if (mem_en && mem_rdy) begin
				if (mem_cmd == cmd_read) begin
					head.due = cycle + 32'(read_latency);
					head.data = read_strip(mem_addr);
					ret_q.push_back(head);
					rd_count <= rd_count + 1;
				end else if (wdata_q.size() > 0) begin
					write_strip(mem_addr, wdata_q.pop_front(), wmask_q.pop_front());
					last_wr_addr <= mem_addr;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/mpmc_tb.sv ====
`default_nettype none

module mpmc_tb
	import mpmc_mem_pkg::*, mpmc_chan_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int rounds_fair = 80;
	localparam int rounds_stall = 40;
	localparam int rounds_max = 80;
	localparam int directed_txns = 7;
	localparam int cycle_limit = 64 * (directed_txns + num_ch * (rounds_fair + rounds_stall));

	logic mem_ui_clk = 1'b0;
	logic mem_ui_rst;
	logic cpu_cyc, cpu_stb, cpu_we;
	logic [7:0] cpu_sel;
	logic [31:0] cpu_adr;
	logic [63:0] cpu_dati, cpu_dato;
	logic cpu_ack;
	logic dma_cyc, dma_stb, dma_we;
	logic [3:0] dma_sel;
	logic [31:0] dma_adr, dma_dati, dma_dato;
	logic dma_ack;
	logic [addr_w-1:0] mem_addr, last_wr_addr;
	logic [2:0] mem_cmd;
	logic mem_en, mem_wdf_wren, mem_wdf_end, mem_rd_data_valid, mem_rdy, mem_wdf_rdy;
	logic [strip_w-1:0] mem_wdf_data, mem_rd_data;
	logic [strip_bytes-1:0] mem_wdf_mask;
	logic rdy_stall = 1'b0;
	logic wdf_stall = 1'b0;
	logic stall_on = 1'b0;
	int rd_count;
	int cycle_cnt = 0;
	logic [15:0] stim_lfsr;
	logic [15:0] stall_lfsr = 16'd3041;

	// Expected memory contents, one entry per written byte
	logic [7:0] shadow [logic [31:0]];
	string name_q [$];
	logic [63:0] got_q [$];
	logic [63:0] exp_q [$];

	logic op_we [num_ch][rounds_max];
	logic [7:0] op_sel [num_ch][rounds_max];
	logic [31:0] op_adr [num_ch][rounds_max];
	logic [63:0] op_dat [num_ch][rounds_max];

	mpmc_top mpmc_top_inst (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst),
		.cpu_cyc(cpu_cyc), .cpu_stb(cpu_stb), .cpu_we(cpu_we), .cpu_sel(cpu_sel),
		.cpu_adr(cpu_adr), .cpu_dati(cpu_dati), .cpu_dato(cpu_dato), .cpu_ack(cpu_ack),
		.dma_cyc(dma_cyc), .dma_stb(dma_stb), .dma_we(dma_we), .dma_sel(dma_sel),
		.dma_adr(dma_adr), .dma_dati(dma_dati), .dma_dato(dma_dato), .dma_ack(dma_ack),
		.mem_addr(mem_addr), .mem_cmd(mem_cmd), .mem_en(mem_en),
		.mem_wdf_data(mem_wdf_data), .mem_wdf_mask(mem_wdf_mask),
		.mem_wdf_wren(mem_wdf_wren), .mem_wdf_end(mem_wdf_end),
		.mem_rd_data(mem_rd_data), .mem_rd_data_valid(mem_rd_data_valid),
		.mem_rdy(mem_rdy), .mem_wdf_rdy(mem_wdf_rdy)
	);

	mig_model mig_model_inst (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst),
		.mem_addr(mem_addr), .mem_cmd(mem_cmd), .mem_en(mem_en),
		.mem_wdf_data(mem_wdf_data), .mem_wdf_mask(mem_wdf_mask),
		.mem_wdf_wren(mem_wdf_wren),
		.mem_rd_data(mem_rd_data), .mem_rd_data_valid(mem_rd_data_valid),
		.mem_rdy(mem_rdy), .mem_wdf_rdy(mem_wdf_rdy),
		.rdy_stall(rdy_stall), .wdf_stall(wdf_stall),
		.rd_count(rd_count), .last_wr_addr(last_wr_addr)
	);

	always #5 mem_ui_clk = ~mem_ui_clk;

	// ==============================
	// Random numbers
	// ==============================

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_next(stim_lfsr);
			v = {v[62:0], stim_lfsr[0]};
		end
	endtask

	// Ready stalls for the memory model
	always @(negedge mem_ui_clk) begin
		stall_lfsr = lfsr_next(stall_lfsr);
		rdy_stall = stall_on && stall_lfsr[0];
		stall_lfsr = lfsr_next(stall_lfsr);
		wdf_stall = stall_on && stall_lfsr[0];
	end

	// ==============================
	// Reference model
	// ==============================

	function automatic logic [7:0] pattern_byte(input logic [addr_w-1:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {3'b000, a[28:24]} ^ 8'ha5;
	endfunction

	function automatic logic [7:0] shadow_byte(input logic [31:0] a);
		return shadow.exists(a) ? shadow[a] : pattern_byte(a[addr_w-1:0]);
	endfunction

	// Little-endian word at the aligned address
	function automatic logic [63:0] expect_word(input logic [31:0] adr, input int nbytes);
		logic [63:0] w;
		logic [31:0] base;
		w = '0;
		base = adr & ~(32'(nbytes) - 32'd1);
		for (int i = 0; i < nbytes; i++)
			w[8*i +: 8] = shadow_byte(base + 32'(i));
		return w;
	endfunction

	task automatic shadow_write(input logic [31:0] adr, input logic [7:0] sel,
			input logic [63:0] wdata, input int nbytes);
		logic [31:0] base;
		base = adr & ~(32'(nbytes) - 32'd1);
		for (int i = 0; i < nbytes; i++) begin
			if (sel[i])
				shadow[base + 32'(i)] = wdata[8*i +: 8];
		end
	endtask

	// ==============================
	// Checking
	// ==============================

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic post_result(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		name_q.push_back(name);
		got_q.push_back(got);
		exp_q.push_back(exp);
	endtask

	always @(posedge mem_ui_clk) begin
		while (got_q.size() > 0)
			check_value(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
	end

	// Writes are single strips, so every data beat also ends its burst
	always @(negedge mem_ui_clk) begin
		if (!mem_ui_rst)
			post_result("mem_wdf_end", {63'd0, mem_wdf_end}, {63'd0, mem_wdf_wren});
	end

	always @(posedge mem_ui_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("*** TEST FAILED ***");
			$fatal(1, "Timeout: the run did not finish within %0d cycles", cycle_limit);
		end
	end

	// ==============================
	// Bus transactions
	// ==============================

	function automatic logic ack_of(input ch_id_t ch);
		return (ch == ch_cpu) ? cpu_ack : dma_ack;
	endfunction

	task automatic drive_bus(input ch_id_t ch, input logic cyc, input logic we,
			input logic [7:0] sel, input logic [31:0] adr, input logic [63:0] wdata);
		if (ch == ch_cpu) begin
			cpu_cyc = cyc;
			cpu_stb = cyc;
			cpu_we = we;
			cpu_sel = sel;
			cpu_adr = adr;
			cpu_dati = wdata;
		end else begin
			dma_cyc = cyc;
			dma_stb = cyc;
			dma_we = we;
			dma_sel = sel[3:0];
			dma_adr = adr;
			dma_dati = wdata[31:0];
		end
	endtask

	// One request, held until ack, released the cycle after
	task automatic bus_op(input ch_id_t ch, input logic we, input logic [7:0] sel,
			input logic [31:0] adr, input logic [63:0] wdata);
		int nbytes;
		logic [63:0] got;
		string name;
		nbytes = (ch == ch_cpu) ? 8 : 4;
		@(negedge mem_ui_clk);
		drive_bus(ch, 1'b1, we, sel, adr, wdata);
		@(negedge mem_ui_clk);
		while (!ack_of(ch))
			@(negedge mem_ui_clk);
		got = (ch == ch_cpu) ? cpu_dato : {32'h0, dma_dato};
		if (we) begin
			shadow_write(adr, sel, wdata, nbytes);
			// The strip must already sit in memory when ack is seen
			name = (ch == ch_cpu) ? "cpu_wr_addr" : "dma_wr_addr";
			post_result(name, {35'd0, last_wr_addr}, {35'd0, adr[28:4], 4'h0});
		end else begin
			name = (ch == ch_cpu) ? "cpu_dato" : "dma_dato";
			post_result(name, got, expect_word(adr, nbytes));
		end
		@(negedge mem_ui_clk);
		drive_bus(ch, 1'b0, 1'b0, 8'h00, 32'h0, 64'h0);
	endtask

	// Channel regions do not overlap, so results do not depend on grant order
	task automatic gen_ops(input int n);
		logic [63:0] r;
		for (int i = 0; i < n; i++) begin
			for (int c = 0; c < num_ch; c++) begin
				rand_bits(1, r);
				op_we[c][i] = r[0];
				rand_bits(8, r);
				op_sel[c][i] = r[7:0];
				rand_bits(64, r);
				op_dat[c][i] = r;
				rand_bits(6, r);
				if (c == 0)
					op_adr[c][i] = 32'h0001_0000 + {23'd0, r[5:0], 3'd0};
				else
					op_adr[c][i] = 32'h0002_0000 + {24'd0, r[5:0], 2'd0};
			end
		end
	endtask

	task automatic run_rounds(input int n);
		gen_ops(n);
		fork
			for (int i = 0; i < n; i++)
				bus_op(ch_cpu, op_we[0][i], op_sel[0][i], op_adr[0][i], op_dat[0][i]);
			for (int j = 0; j < n; j++)
				bus_op(ch_dma, op_we[1][j], op_sel[1][j], op_adr[1][j], op_dat[1][j]);
		join
	endtask

	// ==============================
	// Stimulus
	// ==============================

	initial begin
		int rd0;
		logic [63:0] d;
		mem_ui_rst = 1'b1;
		stim_lfsr = 16'd3041;
		drive_bus(ch_cpu, 1'b0, 1'b0, 8'h00, 32'h0, 64'h0);
		drive_bus(ch_dma, 1'b0, 1'b0, 8'h00, 32'h0, 64'h0);
		repeat (4) @(negedge mem_ui_clk);
		mem_ui_rst = 1'b0;

		// Partial write, then a read miss merges it
		rand_bits(64, d);
		bus_op(ch_cpu, 1'b1, 8'b0011_0101, 32'h0000_1008, d);
		rd0 = rd_count;
		bus_op(ch_cpu, 1'b0, 8'hff, 32'h0000_1008, 64'h0);
		post_result("rd_count", 64'(rd_count - rd0), 64'd2);

		// Hits inside the cached lines
		rd0 = rd_count;
		bus_op(ch_cpu, 1'b0, 8'hff, 32'h0000_1018, 64'h0);
		post_result("rd_count", 64'(rd_count - rd0), 64'd0);
		rd0 = rd_count;
		bus_op(ch_dma, 1'b0, 8'h0f, 32'h0000_2004, 64'h0);
		post_result("rd_count", 64'(rd_count - rd0), 64'd1);
		rd0 = rd_count;
		bus_op(ch_dma, 1'b0, 8'h0f, 32'h0000_200c, 64'h0);
		post_result("rd_count", 64'(rd_count - rd0), 64'd0);

		// dma write into the cpu line forces a refill
		rand_bits(32, d);
		bus_op(ch_dma, 1'b1, 8'b0000_0110, 32'h0000_1014, d);
		rd0 = rd_count;
		bus_op(ch_cpu, 1'b0, 8'hff, 32'h0000_1010, 64'h0);
		post_result("rd_count", 64'(rd_count - rd0), 64'd2);

		run_rounds(rounds_fair);

		stall_on = 1'b1;
		run_rounds(rounds_stall);
		stall_on = 1'b0;

		repeat (4) @(negedge mem_ui_clk);
		if (got_q.size() == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("*** TEST FAILED ***");
			$fatal(1, "Results were left unchecked at the end of the run");
		end
	end

endmodule

`default_nettype wire

// ==== sim.f ====
common/mpmc_mem_pkg.sv
common/mpmc_chan_pkg.sv
hw/channel_port/channel_port.sv
hw/channel_arb.sv
hw/mpmc_ctrl.sv
hw/mem_cmd_path.sv
hw/mpmc_top.sv
bench/mig_model.sv
bench/mpmc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= mpmc_tb
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
SIM_BIN ?= Vmpmc_tb
VFLAGS ?= --binary --assert --timing

SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/$(SIM_BIN)

$(OBJ_DIR)/$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(SIM_BIN)

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./$(OBJ_DIR)/$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
